// ==== verilog/lac_pkg.sv ====
package lac_pkg;

    // --------------------
    // LAC arithmetic
    // --------------------

    // modulus of the LAC scheme
    localparam int lac_q = 251;

    // one coefficient reduced modulo lac_q
    localparam int coeff_width = 8;

    // lane sums are sized for up to this many lanes
    localparam int max_core_num = 16;

    // --------------------
    // coefficient types
    // --------------------

    typedef logic [coeff_width-1:0] coeff_t;

    // even index in the low byte, odd index in the high byte
    typedef logic [2*coeff_width-1:0] coeff_pair_t;

    // unreduced sum of up to max_core_num corrected coefficients
    typedef logic [coeff_width+$clog2(max_core_num)-1:0] lane_sum_t;

endpackage

// ==== verilog/spm_ram.sv ====
`timescale 1ns/10ps

module spm_ram
#(
    parameter int width = 16,
    parameter int depth = 512
)
(
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [width-1:0]         wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [width-1:0]         rd_data
);

    typedef logic [width-1:0] word_t;

    word_t mem [depth];

    // write port and registered read port work independently
    // a read of the address being written returns the old word
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/spm_sequencer.sv ====
`timescale 1ns/10ps

module spm_sequencer
#(
    parameter int n        = 1024,
    parameter int h        = 256,
    parameter int core_num = 4
)
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  logic                            pass_end,
    output logic                            busy,
    output logic                            done,
    output logic                            load_pos,
    output logic                            negate_pass,
    output logic [$clog2(n)-1:0]            pair_index,
    output logic                            first_pass,
    output logic                            acc_rd_start,
    output logic                            acc_wr_start,
    output logic [$clog2(h/core_num)-1:0]   pos_rd_addr
);

    localparam int num_passes = h / core_num;

    // bit i of the strobe chain is high i+1 cycles after a pass kick
    localparam int chain_len       = 9;
    localparam int tap_load_pos    = 1;
    localparam int tap_index_clear = 3;
    localparam int tap_rd_start    = 6;
    localparam int tap_wr_start    = 8;

    typedef enum logic [1:0] {st_idle, st_run, st_done} seq_state_t;
    typedef logic [$clog2(num_passes)-1:0] pass_cnt_t;
    typedef logic [$clog2(n)-1:0] idx_t;

    seq_state_t state;
    pass_cnt_t pass_cnt;
    logic last_pass;
    logic kick;
    logic [chain_len-1:0] strobe_sr;

    assign last_pass = (pass_cnt == pass_cnt_t'(num_passes - 1));

    // a pass begins on start or when a pass that is not the last one ends
    assign kick = start | (pass_end & ~last_pass);

    assign busy = (state != st_idle);
    assign done = (state == st_done);
    assign pos_rd_addr = pass_cnt;

    // passes at or beyond h/2 use the negative coefficients
    assign negate_pass = (int'(pass_cnt) * core_num) >= (h / 2);

    assign load_pos = strobe_sr[tap_load_pos];
    assign acc_rd_start = strobe_sr[tap_rd_start];
    assign acc_wr_start = strobe_sr[tap_wr_start];

    // --------------------
    // run control
    // --------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= st_idle;
            pass_cnt <= '0;
            first_pass <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (start)
                        state <= st_run;
                st_run:
                    if (pass_end && last_pass)
                        state <= st_done;
                default:
                    state <= st_idle;
            endcase

            if (start)
            begin
                pass_cnt <= '0;
                first_pass <= 1'b1;
            end
            else if (pass_end)
            begin
                pass_cnt <= pass_cnt + 1'b1;
                first_pass <= 1'b0;
            end
        end
    end

    // --------------------
    // pipeline strobes
    // --------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            strobe_sr <= '0;
            pair_index <= '0;
        end
        else
        begin
            strobe_sr <= {strobe_sr[chain_len-2:0], kick};
            // index 0 meets the first lane word three cycles after load_pos
            if (strobe_sr[tap_index_clear])
                pair_index <= '0;
            else if (busy)
                pair_index <= pair_index + idx_t'(2);
        end
    end

    a_start_idle : assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy);

    // the accumulator ends passes only while a run is in progress
    a_pass_end_run : assert property (@(posedge clk) disable iff (!arst_n)
        pass_end |-> (state == st_run));

endmodule

// ==== verilog/spm_rotate_lane.sv ====
`timescale 1ns/10ps

module spm_rotate_lane
    import lac_pkg::*;
#(
    parameter int n = 1024
)
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   poly_wr_en,
    input  logic [$clog2(n/2)-1:0] poly_wr_addr,
    input  coeff_pair_t            poly_wr_data,
    input  logic                   load_pos,
    input  logic [$clog2(n)-1:0]   position,
    input  logic                   negate_pass,
    input  logic [$clog2(n)-1:0]   pair_index,
    output coeff_pair_t            term
);

    typedef logic [$clog2(n)-1:0] idx_t;
    typedef logic [$clog2(n/2)-1:0] word_addr_t;

    idx_t offset;
    idx_t pos_q;
    idx_t index_hi;
    word_addr_t rd_addr;
    logic odd_q;
    coeff_pair_t rd_word;
    coeff_pair_t prev_word;
    coeff_t coeff_lo;
    coeff_t coeff_hi;
    logic neg_lo;
    logic neg_hi;

    function automatic coeff_t cond_negate(coeff_t x, logic neg);
        if (neg && (x != '0))
            return coeff_t'(lac_q) - x;
        return x;
    endfunction

    // (n - position) mod n is the dense index that lines up with k = 0
    assign offset = idx_t'(0) - position;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_addr <= '0;
            odd_q <= 1'b0;
            pos_q <= '0;
        end
        else if (load_pos)
        begin
            rd_addr <= offset[$clog2(n)-1:1];
            odd_q <= offset[0];
            pos_q <= position;
        end
        else
        begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // private copy of the dense operand
    spm_ram #(
        .width ($bits(coeff_pair_t)),
        .depth (n / 2)
    ) u_dense_ram (
        .clk     (clk),
        .wr_en   (poly_wr_en),
        .wr_addr (poly_wr_addr),
        .wr_data (poly_wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_word)
    );

    // an odd offset straddles two words and the older one is in prev_word
    assign coeff_lo = odd_q ? prev_word[2*coeff_width-1:coeff_width] : prev_word[coeff_width-1:0];
    assign coeff_hi = odd_q ? rd_word[coeff_width-1:0] : prev_word[2*coeff_width-1:coeff_width];

    // negacyclic wrap flips the sign of the pass
    assign index_hi = pair_index + idx_t'(1);
    assign neg_lo = (pair_index < pos_q) ^ negate_pass;
    assign neg_hi = (index_hi < pos_q) ^ negate_pass;

    always_ff @(posedge clk)
    begin
        prev_word <= rd_word;
        term <= {cond_negate(coeff_hi, neg_hi), cond_negate(coeff_lo, neg_lo)};
    end

endmodule

// ==== verilog/spm_accumulate.sv ====
`timescale 1ns/10ps

module spm_accumulate
    import lac_pkg::*;
#(
    parameter int n        = 1024,
    parameter int core_num = 4
)
(
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [core_num*$bits(coeff_pair_t)-1:0] terms,
    input  logic                                  first_pass,
    input  logic                                  acc_rd_start,
    input  logic                                  acc_wr_start,
    input  coeff_pair_t                           res_rd_data_int,
    output logic [$clog2(n/2)-1:0]                res_rd_addr_int,
    output logic                                  res_wr_en,
    output logic [$clog2(n/2)-1:0]                res_wr_addr,
    output coeff_pair_t                           res_wr_data,
    output logic                                  pass_end
);

    localparam int stages = $clog2(core_num);

    typedef logic [$clog2(n/2)-1:0] word_addr_t;
    // two reduced coefficients added together
    typedef logic [coeff_width:0] coeff_sum_t;

    localparam word_addr_t last_word = word_addr_t'(n / 2 - 1);

    lane_sum_t lane_sum [2];
    lane_sum_t red [2][stages+1];
    coeff_t reduced [2];
    coeff_t part [2];
    coeff_sum_t add_q [2];
    coeff_t wr_coeff [2];

    function automatic lane_sum_t cond_sub(lane_sum_t x, lane_sum_t m);
        return (x >= m) ? x - m : x;
    endfunction

    // --------------------
    // datapath
    // --------------------

    always_comb
    begin
        for (int half = 0; half < 2; half++)
        begin
            lane_sum[half] = '0;
            for (int lane = 0; lane < core_num; lane++)
                lane_sum[half] = lane_sum[half]
                    + lane_sum_t'(terms[(2*lane+half)*coeff_width +: coeff_width]);
            reduced[half] = coeff_t'(red[half][stages]);
            // result RAM holds stale data until the first pass has written it
            part[half] = first_pass ? '0 : res_rd_data_int[half*coeff_width +: coeff_width];
            wr_coeff[half] = (add_q[half] >= coeff_sum_t'(lac_q))
                ? coeff_t'(add_q[half] - coeff_sum_t'(lac_q)) : coeff_t'(add_q[half]);
        end
    end

    // stage s takes off lac_q * 2^(stages-s), leaving a value below lac_q
    always_ff @(posedge clk)
    begin
        for (int half = 0; half < 2; half++)
        begin
            red[half][0] <= lane_sum[half];
            for (int s = 1; s <= stages; s++)
                red[half][s] <= cond_sub(red[half][s-1], lane_sum_t'(lac_q) << (stages - s));
            add_q[half] <= coeff_sum_t'(reduced[half]) + coeff_sum_t'(part[half]);
        end
    end

    assign res_wr_data = {wr_coeff[1], wr_coeff[0]};

    // --------------------
    // sweep addresses
    // --------------------

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            res_rd_addr_int <= '0;
            res_wr_en <= 1'b0;
            res_wr_addr <= '0;
            pass_end <= 1'b0;
        end
        else
        begin
            res_rd_addr_int <= acc_rd_start ? '0 : res_rd_addr_int + 1'b1;
            pass_end <= res_wr_en && (res_wr_addr == last_word);
            if (acc_wr_start)
            begin
                res_wr_en <= 1'b1;
                res_wr_addr <= '0;
            end
            else if (res_wr_en)
            begin
                res_wr_en <= (res_wr_addr != last_word);
                res_wr_addr <= res_wr_addr + 1'b1;
            end
        end
    end

    // each write sweep reaches the last word before the next pass starts its own
    a_sweep_done : assert property (@(posedge clk) disable iff (!arst_n)
        acc_wr_start |-> !res_wr_en);

endmodule

// ==== verilog/sparse_poly_mul.sv ====
`timescale 1ns/10ps

module sparse_poly_mul
    import lac_pkg::*;
#(
    parameter int n        = 1024,
    parameter int h        = 256,
    parameter int core_num = 4
)
(
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               start,
    output logic                               busy,
    output logic                               done,
    input  logic                               poly_wr_en,
    input  logic [$clog2(n/2)-1:0]             poly_wr_addr,
    input  coeff_pair_t                        poly_wr_data,
    input  logic                               pos_wr_en,
    input  logic [$clog2(h/core_num)-1:0]      pos_wr_addr,
    input  logic [core_num*$clog2(n)-1:0]      pos_wr_data,
    input  logic                               res_rd_en,
    input  logic [$clog2(n/2)-1:0]             res_rd_addr,
    output coeff_pair_t                        res_rd_data
);

    localparam int pos_width = $clog2(n);
    localparam int pos_depth = h / core_num;

    typedef logic [pos_width-1:0] pos_t;
    typedef logic [$clog2(n/2)-1:0] word_addr_t;

    logic load_pos;
    logic negate_pass;
    logic first_pass;
    logic acc_rd_start;
    logic acc_wr_start;
    logic pass_end;
    pos_t pair_index;
    logic [$clog2(pos_depth)-1:0] pos_rd_addr;
    logic [core_num*pos_width-1:0] pos_rd_data;
    logic [core_num*$bits(coeff_pair_t)-1:0] terms;
    word_addr_t res_rd_addr_int;
    word_addr_t res_ram_rd_addr;
    word_addr_t res_wr_addr;
    logic res_wr_en;
    coeff_pair_t res_wr_data;
    coeff_pair_t res_rd_data_int;
    logic res_rd_en_q;

    spm_sequencer #(.n(n), .h(h), .core_num(core_num)) u_sequencer (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .pass_end     (pass_end),
        .busy         (busy),
        .done         (done),
        .load_pos     (load_pos),
        .negate_pass  (negate_pass),
        .pair_index   (pair_index),
        .first_pass   (first_pass),
        .acc_rd_start (acc_rd_start),
        .acc_wr_start (acc_wr_start),
        .pos_rd_addr  (pos_rd_addr)
    );

    // position word j holds the positions of lanes 0 to core_num-1
    spm_ram #(.width(core_num * pos_width), .depth(pos_depth)) u_pos_ram (
        .clk     (clk),
        .wr_en   (pos_wr_en),
        .wr_addr (pos_wr_addr),
        .wr_data (pos_wr_data),
        .rd_addr (pos_rd_addr),
        .rd_data (pos_rd_data)
    );

    for (genvar lane = 0; lane < core_num; lane++)
    begin : g_lane
        spm_rotate_lane #(.n(n)) u_lane (
            .clk          (clk),
            .arst_n       (arst_n),
            .poly_wr_en   (poly_wr_en),
            .poly_wr_addr (poly_wr_addr),
            .poly_wr_data (poly_wr_data),
            .load_pos     (load_pos),
            .position     (pos_rd_data[lane*pos_width +: pos_width]),
            .negate_pass  (negate_pass),
            .pair_index   (pair_index),
            .term         (terms[lane*$bits(coeff_pair_t) +: $bits(coeff_pair_t)])
        );
    end

    spm_accumulate #(.n(n), .core_num(core_num)) u_accumulate (
        .clk             (clk),
        .arst_n          (arst_n),
        .terms           (terms),
        .first_pass      (first_pass),
        .acc_rd_start    (acc_rd_start),
        .acc_wr_start    (acc_wr_start),
        .res_rd_data_int (res_rd_data_int),
        .res_rd_addr_int (res_rd_addr_int),
        .res_wr_en       (res_wr_en),
        .res_wr_addr     (res_wr_addr),
        .res_wr_data     (res_wr_data),
        .pass_end        (pass_end)
    );

    // external reads take the port only while the run is idle
    assign res_ram_rd_addr = res_rd_en ? res_rd_addr : res_rd_addr_int;

    spm_ram #(.width($bits(coeff_pair_t)), .depth(n / 2)) u_res_ram (
        .clk     (clk),
        .wr_en   (res_wr_en),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_data),
        .rd_addr (res_ram_rd_addr),
        .rd_data (res_rd_data_int)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            res_rd_en_q <= 1'b0;
        else
            res_rd_en_q <= res_rd_en;
    end

    // output register holds the last externally read word
    always_ff @(posedge clk)
    begin
        if (res_rd_en_q)
            res_rd_data <= res_rd_data_int;
    end

endmodule

// ==== verification/tb_sparse_poly_mul.sv ====
`timescale 1ns/10ps

module tb_sparse_poly_mul
    import lac_pkg::*;
();

    localparam int n            = 16;
    localparam int h            = 8;
    localparam int core_num     = 4;
    localparam int words        = n / 2;
    localparam int pos_words    = h / core_num;
    localparam int case_len     = words + pos_words + words;
    localparam int num_cases    = 2;
    localparam int done_timeout = 500;

    typedef logic [$clog2(n/2)-1:0] word_addr_t;
    typedef logic [$clog2(pos_words)-1:0] pos_addr_t;

    logic clk;
    logic arst_n;
    logic start;
    logic busy;
    logic done;
    logic poly_wr_en;
    word_addr_t poly_wr_addr;
    coeff_pair_t poly_wr_data;
    logic pos_wr_en;
    pos_addr_t pos_wr_addr;
    logic [core_num*$clog2(n)-1:0] pos_wr_data;
    logic res_rd_en;
    word_addr_t res_rd_addr;
    coeff_pair_t res_rd_data;

    // each case holds dense words, then position words, then expected result words
    logic [15:0] golden [num_cases*case_len];

    sparse_poly_mul #(.n(n), .h(h), .core_num(core_num)) UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .poly_wr_en   (poly_wr_en),
        .poly_wr_addr (poly_wr_addr),
        .poly_wr_data (poly_wr_data),
        .pos_wr_en    (pos_wr_en),
        .pos_wr_addr  (pos_wr_addr),
        .pos_wr_data  (pos_wr_data),
        .res_rd_en    (res_rd_en),
        .res_rd_addr  (res_rd_addr),
        .res_rd_data  (res_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // reporting
    // --------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_pair(input string name, input coeff_pair_t got, input coeff_pair_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                $time, name, got, exp));
    endtask

    // --------------------
    // bus actions
    // --------------------

    // all tasks start and end 1 ns after a rising edge
    task automatic load_case(input int c);
        int base;
        base = c * case_len;
        for (int i = 0; i < words; i++)
        begin
            poly_wr_en = 1'b1;
            poly_wr_addr = word_addr_t'(i);
            poly_wr_data = golden[base + i];
            @(posedge clk);
            #1;
        end
        poly_wr_en = 1'b0;
        for (int i = 0; i < pos_words; i++)
        begin
            pos_wr_en = 1'b1;
            pos_wr_addr = pos_addr_t'(i);
            pos_wr_data = golden[base + words + i];
            @(posedge clk);
            #1;
        end
        pos_wr_en = 1'b0;
    endtask

    task automatic run_case();
        int cycles;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cycles = 0;
        while (done !== 1'b1)
        begin
            check_bit("busy", busy, 1'b1);
            if (cycles >= done_timeout)
                abort_run("timeout waiting for done");
            cycles++;
            @(posedge clk);
            #1;
        end
        check_bit("busy", busy, 1'b1);
        // done lasts one cycle and busy drops right after it
        @(posedge clk);
        #1;
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
    endtask

    // output register shows the word two edges after the address
    task automatic read_result(input word_addr_t addr, output coeff_pair_t data);
        res_rd_en = 1'b1;
        res_rd_addr = addr;
        @(posedge clk);
        #1;
        res_rd_en = 1'b0;
        @(posedge clk);
        #1;
        data = res_rd_data;
    endtask

    task automatic check_results(input int c);
        int base;
        coeff_pair_t rd_word;
        base = c * case_len + words + pos_words;
        for (int i = 0; i < words; i++)
        begin
            read_result(word_addr_t'(i), rd_word);
            check_pair($sformatf("res_rd_data[%0d]", i), rd_word, golden[base + i]);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial
    begin
        coeff_pair_t first_read;
        coeff_pair_t second_read;
        arst_n = 1'b0;
        start = 1'b0;
        poly_wr_en = 1'b0;
        poly_wr_addr = '0;
        poly_wr_data = '0;
        pos_wr_en = 1'b0;
        pos_wr_addr = '0;
        pos_wr_data = '0;
        res_rd_en = 1'b0;
        res_rd_addr = '0;
        $readmemh("verification/golden_spm.txt", golden);
        if ($isunknown(golden[num_cases*case_len-1]))
            abort_run("golden file verification/golden_spm.txt is missing or too short");

        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);

        // case 2 follows case 1 directly, so stale results sit in the result RAM
        for (int c = 0; c < num_cases; c++)
        begin
            load_case(c);
            run_case();
            check_results(c);
        end

        read_result(word_addr_t'(3), first_read);
        read_result(word_addr_t'(3), second_read);
        check_pair("res_rd_data[3] second read", second_read, first_read);
        check_pair("res_rd_data[3]", first_read, golden[case_len + words + pos_words + 3]);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verification/golden_spm.txt ====
// one hex word per line, high byte odd coefficient, low byte even coefficient
// per case 8 dense words, 2 position words (lane j at bits 4j), 8 expected result words
// case 1 dense a[j] = j + 1
0201
0403
0605
0807
0A09
0C0B
0E0D
100F
// case 1 positions 0 1 2 3 (+) then 4 8 12 15 (-)
3210
FC84
// case 1 expected result words
05EC
331B
2F29
3B35
332F
3B37
2F2D
2131
// case 2 dense a[j] = 235 + j
ECEB
EEED
F0EF
F2F1
F4F3
F6F5
F8F7
FAF9
// case 2 positions 1 6 9 14 (+) then 0 3 11 13 (-)
E961
DB30
// case 2 expected result words
0113
1101
0D0F
F6F6
E6F6
FAE8
0FFA
F8F8

// ==== files.f ====
verilog/lac_pkg.sv
verilog/spm_ram.sv
verilog/spm_sequencer.sv
verilog/spm_rotate_lane.sv
verilog/spm_accumulate.sv
verilog/sparse_poly_mul.sv
verification/tb_sparse_poly_mul.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_sparse_poly_mul
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
GOLDEN    := verification/golden_spm.txt

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
